// File: tb.f
source/cache_pkg.sv
source/sp_ram.sv
source/tag_access.sv
source/data_access.sv
source/cache_bank.sv
bench/tb_mem_model.sv
bench/tb_cache_bank.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_cache_bank -f tb.f -o sim_tb_cache_bank || exit 1
out="$(./obj_dir/sim_tb_cache_bank)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// File: bench/tb_cache_bank.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cache_bank import cache_pkg::*; ();

    typedef struct packed {
        core_req_t req;
        logic      fetch;
    } entry_t;

    // cycle is zero where any cycle will do.
    typedef struct packed {
        int        entry;
        int        cycle;
        core_rsp_t rsp;
    } rsp_exp_t;

    typedef struct packed {
        int       entry;
        int       cycle;
        mem_req_t req;
    } mem_exp_t;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    core_req_t req;
    logic      busy;
    logic      rsp_valid;
    core_rsp_t rsp;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_rsp_valid;
    mem_rsp_t  mem_rsp;

    entry_t   table_q [$];
    rsp_exp_t exp_rsp [$];
    mem_exp_t exp_mem [$];
    line_t    shadow [1 << LINE_ADDR_W];
    int       entry_errors [];
    int       error_count = 0;
    int       done_count = 0;
    int       pass_count = 0;
    int       cycle = 0;

    cache_bank u_cache_bank (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .busy          (busy),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    tb_mem_model #(.SEED(59568)) u_mem_model (
        .clk           (clk),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ########################################
    // helpers
    // ########################################

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic port_req_t make_port(input logic en, input logic [WSEL_W-1:0] wsel,
                                            input logic [WORD_BYTES-1:0] byteen,
                                            input word_t data);
        port_req_t p;
        p.en     = en;
        p.wsel   = wsel;
        p.byteen = byteen;
        p.data   = data;
        return p;
    endfunction

    function automatic port_req_t rd_port(input logic [WSEL_W-1:0] wsel);
        return make_port(1'b1, wsel, '0, '0);
    endfunction

    task automatic add_entry(input logic rw, input logic [LINE_ADDR_W-1:0] line_addr,
                             input port_req_t p0, input port_req_t p1, input logic fetch);
        entry_t e;
        e.req.rw        = rw;
        e.req.line_addr = line_addr;
        e.req.ports[0]  = p0;
        e.req.ports[1]  = p1;
        e.fetch         = fetch;
        table_q.push_back(e);
    endtask

    task automatic note_error(input int idx);
        error_count++;
        if (idx >= 0) begin
            entry_errors[idx]++;
        end
    endtask

    task automatic finish_entry(input int idx);
        done_count++;
        if (entry_errors[idx] == 0) begin
            pass_count++;
        end
        $display("entry %0d %s line %03h: %s", idx, table_q[idx].req.rw ? "write" : "read",
                 table_q[idx].req.line_addr, entry_errors[idx] == 0 ? "ok" : "failed");
    endtask

    task automatic check_rsp(input core_rsp_t got, input core_rsp_t exp, input int idx);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (got.data[p] !== exp.data[p]) begin
                $display("FAIL %0t rsp.data[%0d] got %h expected %h",
                         $time, p, got.data[p], exp.data[p]);
                note_error(idx);
            end
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp, input int idx);
        logic [LINE_W-1:0] mask;
        logic [LINE_W-1:0] got_bits;
        logic [LINE_W-1:0] exp_bits;
        mask = '0;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (exp.be[b]) begin
                mask[b*8 +: 8] = 8'hff;
            end
        end
        got_bits = got.data & mask;
        exp_bits = exp.data & mask;
        if (got.wr !== exp.wr) begin
            $display("FAIL %0t mem_req.wr got %b expected %b", $time, got.wr, exp.wr);
            note_error(idx);
        end
        if (got.line_addr !== exp.line_addr) begin
            $display("FAIL %0t mem_req.line_addr got %h expected %h",
                     $time, got.line_addr, exp.line_addr);
            note_error(idx);
        end
        if (got.be !== exp.be) begin
            $display("FAIL %0t mem_req.be got %h expected %h", $time, got.be, exp.be);
            note_error(idx);
        end
        if (got_bits !== exp_bits) begin
            $display("FAIL %0t mem_req.data got %h expected %h", $time, got_bits, exp_bits);
            note_error(idx);
        end
    endtask

    // the last enabled port that selects a word decides that word.
    task automatic expect_entry(input int idx);
        entry_t            e;
        rsp_exp_t          r;
        mem_exp_t          m;
        logic [LINE_W-1:0] old_bits;
        logic [LINE_W-1:0] new_bits;
        e       = table_q[idx];
        m.entry = idx;
        m.cycle = cycle + 1;
        m.req   = '0;
        m.req.wr        = e.req.rw;
        m.req.line_addr = e.req.line_addr;
        if (e.req.rw) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                for (int p = NUM_PORTS - 1; p >= 0; p--) begin
                    if (e.req.ports[p].en && e.req.ports[p].wsel == w) begin
                        m.req.data[w] = e.req.ports[p].data;
                        m.req.be[w*WORD_BYTES +: WORD_BYTES] = e.req.ports[p].byteen;
                        break;
                    end
                end
            end
            old_bits = shadow[e.req.line_addr];
            new_bits = m.req.data;
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (m.req.be[b]) begin
                    old_bits[b*8 +: 8] = new_bits[b*8 +: 8];
                end
            end
            shadow[e.req.line_addr] = old_bits;
            exp_mem.push_back(m);
        end else begin
            if (e.fetch) begin
                exp_mem.push_back(m);
            end
            r.entry = idx;
            r.cycle = e.fetch ? 0 : cycle + 1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                r.rsp.data[p] = e.req.ports[p].en ?
                                shadow[e.req.line_addr][e.req.ports[p].wsel] : '0;
            end
            exp_rsp.push_back(r);
        end
    endtask

    // ########################################
    // monitor
    // ########################################

    initial begin
        rsp_exp_t r;
        mem_exp_t m;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && mem_req_valid) begin
                if (exp_mem.size() == 0) begin
                    $display("memory request at %0t when none was expected", $time);
                    note_error(-1);
                end else begin
                    m = exp_mem.pop_front();
                    if (m.cycle != cycle) begin
                        $display("entry %0d memory request in cycle %0d, not in cycle %0d",
                                 m.entry, cycle, m.cycle);
                        note_error(m.entry);
                    end
                    check_mem_req(mem_req, m.req, m.entry);
                    if (m.req.wr) begin
                        finish_entry(m.entry);
                    end
                end
            end
            if (rst_n && rsp_valid) begin
                if (exp_rsp.size() == 0) begin
                    $display("response at %0t when none was expected", $time);
                    note_error(-1);
                end else begin
                    r = exp_rsp.pop_front();
                    if (r.cycle != 0 && r.cycle != cycle) begin
                        $display("entry %0d response in cycle %0d, not in cycle %0d",
                                 r.entry, cycle, r.cycle);
                        note_error(r.entry);
                    end
                    if (exp_mem.size() != 0 && exp_mem[0].entry == r.entry) begin
                        $display("entry %0d responded before its line was fetched", r.entry);
                        note_error(r.entry);
                    end
                    check_rsp(rsp, r.rsp, r.entry);
                    finish_entry(r.entry);
                end
            end
        end
    end

    initial begin
        #1;
        repeat (8 + 10 + 40 * table_q.size()) @(posedge clk);
        $display("watchdog expired with %0d of %0d entries done", done_count, table_q.size());
        $display("ERRORS FOUND");
        $finish;
    end

    // ########################################
    // stimulus
    // ########################################

    initial begin
        logic [31:0] rng;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        add_entry(1'b0, 10'h025, rd_port(2'd0), rd_port(2'd3), 1'b1);
        add_entry(1'b0, 10'h025, rd_port(2'd1), '0, 1'b0);
        add_entry(1'b0, 10'h025, rd_port(2'd2), rd_port(2'd3), 1'b0);
        add_entry(1'b1, 10'h025, make_port(1'b1, 2'd1, 4'b0011, 32'ha1a2a3a4),
                  make_port(1'b1, 2'd1, 4'b1100, 32'hb1b2b3b4), 1'b0);
        add_entry(1'b1, 10'h025, make_port(1'b1, 2'd0, 4'b0101, 32'hc1c2c3c4),
                  make_port(1'b1, 2'd2, 4'b1000, 32'hd1d2d3d4), 1'b0);
        add_entry(1'b0, 10'h025, rd_port(2'd1), rd_port(2'd0), 1'b0);
        add_entry(1'b0, 10'h025, rd_port(2'd2), rd_port(2'd3), 1'b0);
        add_entry(1'b1, 10'h13a, make_port(1'b1, 2'd3, 4'b1111, 32'h11223344),
                  make_port(1'b1, 2'd0, 4'b0110, 32'h55667788), 1'b0);
        add_entry(1'b0, 10'h13a, rd_port(2'd3), rd_port(2'd0), 1'b1);
        add_entry(1'b0, 10'h0a5, rd_port(2'd0), rd_port(2'd1), 1'b1);
        add_entry(1'b0, 10'h025, rd_port(2'd1), rd_port(2'd2), 1'b1);
        add_entry(1'b0, 10'h025, '0, rd_port(2'd0), 1'b0);
        add_entry(1'b0, 10'h0a5, rd_port(2'd3), rd_port(2'd2), 1'b1);
        entry_errors = new[table_q.size()];
        rng = 32'd59568;
        for (int a = 0; a < (1 << LINE_ADDR_W); a++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                rng          = xorshift32(rng);
                shadow[a][w] = rng;
            end
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        if (busy !== 1'b0 || rsp_valid !== 1'b0 || mem_req_valid !== 1'b0) begin
            $display("busy, rsp_valid or mem_req_valid is not low after reset");
            note_error(-1);
        end
        for (int i = 0; i < table_q.size(); i++) begin
            while (busy) begin
                @(posedge clk);
                #2;
            end
            expect_entry(i);
            req_valid = 1'b1;
            req       = table_q[i].req;
            @(posedge clk);
            #2;
            req_valid = 1'b0;
        end
        while (exp_rsp.size() != 0 || exp_mem.size() != 0 || busy) begin
            @(posedge clk);
            #2;
        end
        repeat (2) @(posedge clk);
        if (done_count != table_q.size()) begin
            $display("only %0d of %0d entries completed", done_count, table_q.size());
            note_error(-1);
        end
        $display("entries %0d, passed %0d, failed %0d, errors %0d",
                 table_q.size(), pass_count, table_q.size() - pass_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model import cache_pkg::*; #(
    parameter int unsigned SEED = 59568
) (
    input  wire           clk,
    input  wire           mem_req_valid,
    input  wire mem_req_t mem_req,
    output logic          mem_rsp_valid,
    output mem_rsp_t      mem_rsp
);

    line_t             mem [1 << LINE_ADDR_W];
    logic [31:0]       rng;
    mem_req_t          req;
    logic [LINE_W-1:0] old_bits;
    logic [LINE_W-1:0] new_bits;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        rng           = SEED;
        for (int a = 0; a < (1 << LINE_ADDR_W); a++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                rng       = xorshift32(rng);
                mem[a][w] = rng;
            end
        end
        // a request is picked up 1 ns into the cycle that carries it.
        forever begin
            @(posedge clk);
            #1;
            if (mem_req_valid) begin
                req = mem_req;
                if (req.wr) begin
                    old_bits = mem[req.line_addr];
                    new_bits = req.data;
                    for (int b = 0; b < LINE_BYTES; b++) begin
                        if (req.be[b]) begin
                            old_bits[b*8 +: 8] = new_bits[b*8 +: 8];
                        end
                    end
                    mem[req.line_addr] = old_bits;
                end else begin
                    rng = xorshift32(rng);
                    repeat ((rng % 4) + 1) @(posedge clk);
                    #2;
                    mem_rsp.data  = mem[req.line_addr];
                    mem_rsp_valid = 1'b1;
                    @(posedge clk);
                    #2;
                    mem_rsp_valid = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/cache_bank.sv
`timescale 1ns/1ns
`default_nettype none

module cache_bank import cache_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            req_valid,
    input  wire core_req_t req,
    output logic           busy,
    output logic           rsp_valid,
    output core_rsp_t      rsp,
    output logic           mem_req_valid,
    output mem_req_t       mem_req,
    input  wire            mem_rsp_valid,
    input  wire mem_rsp_t  mem_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_FILL,
        ST_REPLAY,
        ST_RESPOND
    } miss_state_t;

    miss_state_t               state_q;
    miss_state_t               state_d;
    logic                      s1_valid_q;
    core_req_t                 s1_req_q;
    logic                      accept;
    logic                      hit;
    logic                      s1_write;
    logic                      s1_read_hit;
    logic                      s1_read_miss;
    logic                      fill;
    logic                      data_write;
    logic [LINE_ADDR_W-1:0]    ram_addr;
    port_req_t [NUM_PORTS-1:0] ram_ports;
    word_t [NUM_PORTS-1:0]     read_words;

    // ########################################
    // request stage
    // ########################################

    assign accept = req_valid & ~busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_req_q <= req;
        end
    end

    assign s1_write     = s1_valid_q & s1_req_q.rw;
    assign s1_read_hit  = s1_valid_q & ~s1_req_q.rw & hit;
    assign s1_read_miss = s1_valid_q & ~s1_req_q.rw & ~hit;

    assign busy = (state_q != ST_IDLE) | s1_write | s1_read_miss;

    // while busy the RAMs serve the held request, otherwise the incoming one.
    assign ram_addr  = busy ? s1_req_q.line_addr : req.line_addr;
    assign ram_ports = busy ? s1_req_q.ports : req.ports;

    assign fill       = (state_q == ST_WAIT_FILL) & mem_rsp_valid;
    assign data_write = s1_write & hit;

    tag_access u_tag_access (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (ram_addr[LINE_SEL_W-1:0]),
        .lookup_tag (ram_addr[LINE_ADDR_W-1:LINE_SEL_W]),
        .fill       (fill),
        .fill_tag   (s1_req_q.line_addr[LINE_ADDR_W-1:LINE_SEL_W]),
        .hit        (hit)
    );

    data_access u_data_access (
        .clk        (clk),
        .index      (ram_addr[LINE_SEL_W-1:0]),
        .write      (data_write),
        .ports      (ram_ports),
        .fill       (fill),
        .fill_data  (mem_rsp.data),
        .read_words (read_words)
    );

    // ########################################
    // miss controller
    // ########################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:      if (s1_read_miss) state_d = ST_WAIT_FILL;
            ST_WAIT_FILL: if (mem_rsp_valid) state_d = ST_REPLAY;
            // the RAMs read the freshly filled line here.
            ST_REPLAY:    state_d = ST_RESPOND;
            default:      state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ########################################
    // memory and core responses
    // ########################################

    assign mem_req_valid     = s1_write | s1_read_miss;
    assign mem_req.wr        = s1_req_q.rw;
    assign mem_req.line_addr = s1_req_q.line_addr;
    assign mem_req.data      = merge_data(s1_req_q.ports);
    assign mem_req.be        = s1_req_q.rw ? merge_be(s1_req_q.ports) : '0;

    assign rsp_valid = s1_read_hit | (state_q == ST_RESPOND);
    assign rsp.data  = read_words;

endmodule

`default_nettype wire

// File: source/data_access.sv
`timescale 1ns/1ns
`default_nettype none

module data_access import cache_pkg::*; (
    input  wire                            clk,
    input  wire [LINE_SEL_W-1:0]           index,
    input  wire                            write,
    input  wire port_req_t [NUM_PORTS-1:0] ports,
    input  wire                            fill,
    input  wire line_t                     fill_data,
    output word_t [NUM_PORTS-1:0]          read_words
);

    line_t                         wr_line;
    line_be_t                      wr_be;
    line_t                         rd_line;
    logic [NUM_PORTS-1:0]          en_q;
    logic [NUM_PORTS-1:0][WSEL_W-1:0] wsel_q;

    // ########################################
    // write side
    // ########################################

    // write and fill never come in the same cycle.
    always_comb begin
        if (write) begin
            wr_line = merge_data(ports);
            wr_be   = merge_be(ports);
        end else begin
            wr_line = fill_data;
            wr_be   = {LINE_BYTES{fill}};
        end
    end

    sp_ram #(
        .word_t (line_t),
        .DEPTH  (LINES),
        .NBE    (LINE_BYTES)
    ) u_data_ram (
        .clk   (clk),
        .addr  (index),
        .wren  (wr_be),
        .wdata (wr_line),
        .rdata (rd_line)
    );

    // ########################################
    // read side
    // ########################################

    // word selects follow the RAM read by one cycle.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            en_q[i]   <= ports[i].en;
            wsel_q[i] <= ports[i].wsel;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (en_q[i]) begin
                read_words[i] = rd_line[wsel_q[i]];
            end else begin
                read_words[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/tag_access.sv
`timescale 1ns/1ns
`default_nettype none

module tag_access import cache_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [LINE_SEL_W-1:0] index,
    input  wire [TAG_W-1:0]      lookup_tag,
    input  wire                  fill,
    input  wire [TAG_W-1:0]      fill_tag,
    output logic                 hit
);

    logic [LINES-1:0]      valid_q;
    logic [LINE_SEL_W-1:0] index_q;
    logic [TAG_W-1:0]      tag_q;
    tag_entry_t            wr_entry;
    tag_entry_t            rd_entry;

    // ########################################
    // tag store
    // ########################################

    assign wr_entry.valid = 1'b1;
    assign wr_entry.tag   = fill_tag;

    sp_ram #(
        .word_t (tag_entry_t),
        .DEPTH  (LINES),
        .NBE    (1)
    ) u_tag_ram (
        .clk   (clk),
        .addr  (index),
        .wren  (fill),
        .wdata (wr_entry),
        .rdata (rd_entry)
    );

    // the valid bits sit in flops so that reset invalidates every line at once.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[index] <= 1'b1;
        end
    end

    // ########################################
    // hit compare
    // ########################################

    // index and tag are held to line up with the registered RAM output.
    always_ff @(posedge clk) begin
        index_q <= index;
        tag_q   <= lookup_tag;
    end

    assign hit = valid_q[index_q] & (rd_entry.tag == tag_q);

endmodule

`default_nettype wire

// File: source/sp_ram.sv
`timescale 1ns/1ns
`default_nettype none

module sp_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 16,
    parameter int  NBE    = 4
) (
    input  wire                     clk,
    input  wire [$clog2(DEPTH)-1:0] addr,
    input  wire [NBE-1:0]           wren,
    input  wire word_t              wdata,
    output word_t                   rdata
);

    localparam int DATA_W = $bits(word_t);
    localparam int LANE_W = DATA_W / NBE;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DATA_W-1:0] wbits;
    logic [DATA_W-1:0] rbits;

    assign wbits = wdata;

    // the read returns the old contents when the same entry is written.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NBE; i++) begin
            if (wren[i]) begin
                mem[addr][i*LANE_W +: LANE_W] <= wbits[i*LANE_W +: LANE_W];
            end
        end
        rbits <= mem[addr];
    end

    assign rdata = rbits;

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // ########################################
    // geometry
    // ########################################

    localparam int WORD_BYTES     = 4;
    localparam int WORD_W         = WORD_BYTES * 8;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BYTES     = WORD_BYTES * WORDS_PER_LINE;
    localparam int LINE_W         = LINE_BYTES * 8;
    localparam int NUM_PORTS      = 2;
    localparam int LINES          = 16;
    localparam int LINE_SEL_W     = $clog2(LINES);
    localparam int LINE_ADDR_W    = 10;
    localparam int TAG_W          = LINE_ADDR_W - LINE_SEL_W;
    localparam int WSEL_W         = $clog2(WORDS_PER_LINE);

    // ########################################
    // line layout and request types
    // ########################################

    typedef logic [WORD_W-1:0] word_t;
    typedef word_t [WORDS_PER_LINE-1:0] line_t;
    typedef logic [LINE_BYTES-1:0] line_be_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic                  en;
        logic [WSEL_W-1:0]     wsel;
        logic [WORD_BYTES-1:0] byteen;
        word_t                 data;
    } port_req_t;

    typedef struct packed {
        logic                         rw;
        logic [LINE_ADDR_W-1:0]       line_addr;
        port_req_t [NUM_PORTS-1:0]    ports;
    } core_req_t;

    typedef struct packed {
        word_t [NUM_PORTS-1:0] data;
    } core_rsp_t;

    typedef struct packed {
        logic                   wr;
        logic [LINE_ADDR_W-1:0] line_addr;
        line_t                  data;
        line_be_t               be;
    } mem_req_t;

    typedef struct packed {
        line_t data;
    } mem_rsp_t;

    // ########################################
    // port merge into a line
    // ########################################

    // a later port wins over an earlier one that selects the same word.
    function automatic line_t merge_data(input port_req_t [NUM_PORTS-1:0] ports);
        line_t line;
        line = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (ports[i].en) begin
                line[ports[i].wsel] = ports[i].data;
            end
        end
        return line;
    endfunction

    // bytes of words that no enabled port selects stay disabled.
    function automatic line_be_t merge_be(input port_req_t [NUM_PORTS-1:0] ports);
        line_be_t be;
        be = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (ports[i].en) begin
                be[ports[i].wsel*WORD_BYTES +: WORD_BYTES] = ports[i].byteen;
            end
        end
        return be;
    endfunction

endpackage

`default_nettype wire
